/* Makefile */
# Verilator build and run of the bit-scan unit testbench

VERILATOR ?= verilator
TOP       ?= nx_bitscan_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= src.f
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard design/*.sv design/*.svh dv/*.sv)
BINARY  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BINARY)

# Rebuilt only when a source or the file list changes
$(OBJ_DIR)/V%: $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $* -Mdir $(OBJ_DIR) -o V$*

# The log decides the result, the simulator exit code does not
run: $(BINARY)
	./$(BINARY) | tee $(LOG)
	@grep -q "TEST PASSED" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* design/nx_bitscan_config.svh */
// Bit-scan unit configuration: lane count and operand width
`ifndef NX_BITSCAN_CONFIG_SVH
`define NX_BITSCAN_CONFIG_SVH

// Number of parallel scan lanes
`define NX_LANES 4

// Operand width per lane, in bits
// Count width in the result package follows from this
`define NX_DATA_WIDTH 32

`endif

/* design/nx_bitscan_top.sv */
// Four-lane bit-scan unit: dispatch, parallel scan lanes and result collection
`timescale 1ns/100ps
`include "nx_bitscan_config.svh"

module nx_bitscan_top (
    input  logic                                          clk,
    input  logic                                          rst_n,
    // Request, accepted every cycle
    input  logic                                          in_valid,
    input  nx_scan_op_pkg::scan_op_t                      in_op,
    input  logic [`NX_LANES-1:0]                          in_mask,
    input  logic [`NX_LANES-1:0][`NX_DATA_WIDTH-1:0]      in_data,
    // Result, three cycles after the request
    output logic                                          out_valid,
    output logic [`NX_LANES-1:0]                          out_mask,
    output nx_scan_result_pkg::scan_count_t [`NX_LANES-1:0] out_count,
    output logic [`NX_LANES-1:0][`NX_DATA_WIDTH-1:0]      out_data,
    output logic [`NX_LANES-1:0]                          out_zero,
    output nx_scan_result_pkg::scan_count_t               out_min_count
);

    import nx_scan_op_pkg::*;
    import nx_scan_result_pkg::*;

    // Dispatch to lanes
    logic [`NX_LANES-1:0]                     lane_valid;
    scan_op_t                                 lane_op;
    logic [`NX_LANES-1:0][`NX_DATA_WIDTH-1:0] lane_data;
    // Dispatch to collect
    logic                                     req_valid;
    logic [`NX_LANES-1:0]                     req_mask;
    // Lanes to collect
    logic [`NX_LANES-1:0]                     res_valid;
    scan_count_t [`NX_LANES-1:0]              res_count;
    logic [`NX_LANES-1:0][`NX_DATA_WIDTH-1:0] res_data;
    logic [`NX_LANES-1:0]                     res_zero;

    nx_scan_dispatch nx_scan_dispatch_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_op      (in_op),
        .in_mask    (in_mask),
        .in_data    (in_data),
        .lane_valid (lane_valid),
        .lane_op    (lane_op),
        .lane_data  (lane_data),
        .req_valid  (req_valid),
        .req_mask   (req_mask)
    );

    // One scan lane per operand slot, sharing the op code
    for (genvar i = 0; i < `NX_LANES; i++) begin : gen_lane
        nx_scan_lane nx_scan_lane_inst (
            .clk        (clk),
            .rst_n      (rst_n),
            .lane_valid (lane_valid[i]),
            .lane_op    (lane_op),
            .lane_data  (lane_data[i]),
            .res_valid  (res_valid[i]),
            .res_count  (res_count[i]),
            .res_data   (res_data[i]),
            .res_zero   (res_zero[i])
        );
    end

    nx_scan_collect nx_scan_collect_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .res_valid     (res_valid),
        .res_count     (res_count),
        .res_data      (res_data),
        .res_zero      (res_zero),
        .req_valid     (req_valid),
        .req_mask      (req_mask),
        .out_valid     (out_valid),
        .out_mask      (out_mask),
        .out_count     (out_count),
        .out_data      (out_data),
        .out_zero      (out_zero),
        .out_min_count (out_min_count)
    );

endmodule : nx_bitscan_top

/* design/nx_clz.sv */
// Leading-zero counter built from 8-bit priority sections, optionally scanning from bit 0
`timescale 1ns/100ps

module nx_clz #(
    // Operand width
    parameter int WIDTH         = 8,
    // Set to scan from the LSB, giving a trailing-zero count
    parameter bit REVERSE_INPUT = 1'b0
) (
    input  logic [WIDTH-1:0]       scalar_i,
    output logic [$clog2(WIDTH):0] leading_o
);

    localparam int COUNT_WIDTH = $clog2(WIDTH) + 1;
    localparam int SECT_SIZE   = 8;
    localparam int NUM_SECTS   = (WIDTH + SECT_SIZE - 1) / SECT_SIZE;
    localparam int PAD_WIDTH   = NUM_SECTS * SECT_SIZE;
    localparam int SECT_WIDTH  = $clog2(SECT_SIZE) + 1;

    // Bit 0 of ordered is the first bit the scan looks at
    logic [WIDTH-1:0]                      ordered;
    logic [PAD_WIDTH-1:0]                  padded;
    logic [NUM_SECTS-1:0]                  sect_hit;
    logic [NUM_SECTS-1:0][SECT_WIDTH-1:0]  sect_count;
    logic [NUM_SECTS-1:0]                  prior_hit;
    logic [NUM_SECTS-1:0][COUNT_WIDTH-1:0] running;

    // MSB-first scan flips the operand, LSB-first takes it as is
    for (genvar b = 0; b < WIDTH; b++) begin : gen_order
        assign ordered[b] = REVERSE_INPUT ? scalar_i[b] : scalar_i[WIDTH-1-b];
    end

    // Fill with ones above the operand
    // An empty operand then stops at exactly WIDTH
    always_comb begin
        padded = '1;
        padded[WIDTH-1:0] = ordered;
    end

    // Per section: any bit set, and zeros before the first one
    for (genvar s = 0; s < NUM_SECTS; s++) begin : gen_sect
        logic [SECT_SIZE-1:0] sect;

        assign sect        = padded[s*SECT_SIZE +: SECT_SIZE];
        assign sect_hit[s] = |sect;

        always_comb begin
            casez (sect)
                8'b????_???1: sect_count[s] = 4'd0;
                8'b????_??10: sect_count[s] = 4'd1;
                8'b????_?100: sect_count[s] = 4'd2;
                8'b????_1000: sect_count[s] = 4'd3;
                8'b???1_0000: sect_count[s] = 4'd4;
                8'b??10_0000: sect_count[s] = 4'd5;
                8'b?100_0000: sect_count[s] = 4'd6;
                8'b1000_0000: sect_count[s] = 4'd7;
                default:      sect_count[s] = 4'd8;
            endcase
        end
    end

    // Running total, frozen once an earlier section held a one
    for (genvar s = 0; s < NUM_SECTS; s++) begin : gen_sum
        if (s == 0) begin : gen_first
            assign prior_hit[s] = 1'b0;
            assign running[s]   = COUNT_WIDTH'(sect_count[s]);
        end else begin : gen_next
            assign prior_hit[s] = prior_hit[s-1] | sect_hit[s-1];
            assign running[s]   = running[s-1]
                                + (prior_hit[s] ? '0 : COUNT_WIDTH'(sect_count[s]));
        end
    end

    // Last stage holds the full count
    assign leading_o = running[NUM_SECTS-1];

endmodule : nx_clz

/* design/nx_scan_collect.sv */
// Result collection: registers lane results and finds the minimum count over masked lanes
`timescale 1ns/100ps
`include "nx_bitscan_config.svh"

module nx_scan_collect (
    input  logic                                          clk,
    input  logic                                          rst_n,
    // From the lanes
    input  logic [`NX_LANES-1:0]                          res_valid,
    input  nx_scan_result_pkg::scan_count_t [`NX_LANES-1:0] res_count,
    input  logic [`NX_LANES-1:0][`NX_DATA_WIDTH-1:0]      res_data,
    input  logic [`NX_LANES-1:0]                          res_zero,
    // Request tag from dispatch, one stage ahead of the lanes
    input  logic                                          req_valid,
    input  logic [`NX_LANES-1:0]                          req_mask,
    // Unit outputs
    output logic                                          out_valid,
    output logic [`NX_LANES-1:0]                          out_mask,
    output nx_scan_result_pkg::scan_count_t [`NX_LANES-1:0] out_count,
    output logic [`NX_LANES-1:0][`NX_DATA_WIDTH-1:0]      out_data,
    output logic [`NX_LANES-1:0]                          out_zero,
    output nx_scan_result_pkg::scan_count_t               out_min_count
);

    import nx_scan_result_pkg::*;

    // Request tag lined up with the lane results
    logic                 align_valid;
    logic [`NX_LANES-1:0] align_mask;
    scan_count_t          min_count;

    // Tag delay and output strobe
    // Empty-mask requests still reach out_valid
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            align_valid <= 1'b0;
            out_valid   <= 1'b0;
        end else begin
            align_valid <= req_valid;
            out_valid   <= align_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            align_mask <= req_mask;
        end
    end

    // Smallest count among masked lanes
    // Stays at full scale for an empty mask
    always_comb begin
        min_count = scan_count_t'(COUNT_MAX);
        for (int i = 0; i < `NX_LANES; i++) begin
            if (align_mask[i] && (res_count[i] < min_count)) begin
                min_count = res_count[i];
            end
        end
    end

    // Lanes load individually on their own strobe
    // Unmasked lanes keep their last result
    always_ff @(posedge clk) begin
        for (int i = 0; i < `NX_LANES; i++) begin
            if (res_valid[i]) begin
                out_count[i] <= res_count[i];
                out_data[i]  <= res_data[i];
                out_zero[i]  <= res_zero[i];
            end
        end
        if (align_valid) begin
            out_mask      <= align_mask;
            out_min_count <= min_count;
        end
    end

    // Lane strobes two stages after dispatch match the delayed request tag
    a_res_in_mask : assert property (@(posedge clk) disable iff (!rst_n)
        |res_valid |-> align_valid && ((res_valid & ~align_mask) == '0));

endmodule : nx_scan_collect

/* design/nx_scan_dispatch.sv */
// Request dispatch that registers an operation and raises a valid strobe per masked lane
`timescale 1ns/100ps
`include "nx_bitscan_config.svh"

module nx_scan_dispatch (
    input  logic                                     clk,
    input  logic                                     rst_n,
    // Request side
    input  logic                                     in_valid,
    input  nx_scan_op_pkg::scan_op_t                 in_op,
    input  logic [`NX_LANES-1:0]                     in_mask,
    input  logic [`NX_LANES-1:0][`NX_DATA_WIDTH-1:0] in_data,
    // Lane side
    output logic [`NX_LANES-1:0]                     lane_valid,
    output nx_scan_op_pkg::scan_op_t                 lane_op,
    output logic [`NX_LANES-1:0][`NX_DATA_WIDTH-1:0] lane_data,
    // Request tag to collect where it waits one more stage
    output logic                                     req_valid,
    output logic [`NX_LANES-1:0]                     req_mask
);

    // Lane strobes are the request strobe gated per lane by the mask
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_valid  <= 1'b0;
            lane_valid <= '0;
        end else begin
            req_valid  <= in_valid;
            lane_valid <= in_valid ? in_mask : '0;
        end
    end

    // Operation, operands and mask load only on an accepted request
    // All lanes share one op code
    always_ff @(posedge clk) begin
        if (in_valid) begin
            lane_op   <= in_op;
            lane_data <= in_data;
            req_mask  <= in_mask;
        end
    end

endmodule : nx_scan_dispatch

/* design/nx_scan_lane.sv */
// Scan lane doing one registered clz, ctz or normalize on a single operand
`timescale 1ns/100ps
`include "nx_bitscan_config.svh"

module nx_scan_lane (
    input  logic                            clk,
    input  logic                            rst_n,
    // From dispatch
    input  logic                            lane_valid,
    input  nx_scan_op_pkg::scan_op_t        lane_op,
    input  logic [`NX_DATA_WIDTH-1:0]       lane_data,
    // To collect
    output logic                            res_valid,
    output nx_scan_result_pkg::scan_count_t res_count,
    output logic [`NX_DATA_WIDTH-1:0]       res_data,
    output logic                            res_zero
);

    import nx_scan_op_pkg::*;
    import nx_scan_result_pkg::*;

    scan_count_t               lead_count;
    scan_count_t               trail_count;
    scan_count_t               sel_count;
    logic [`NX_DATA_WIDTH-1:0] sel_data;
    // Registered result came from a normalize
    logic                      res_norm;

    // Scan from the MSB
    nx_clz #(
        .WIDTH         (`NX_DATA_WIDTH),
        .REVERSE_INPUT (1'b0)
    ) nx_clz_lead_inst (
        .scalar_i  (lane_data),
        .leading_o (lead_count)
    );

    // Scan from the LSB
    nx_clz #(
        .WIDTH         (`NX_DATA_WIDTH),
        .REVERSE_INPUT (1'b1)
    ) nx_clz_trail_inst (
        .scalar_i  (lane_data),
        .leading_o (trail_count)
    );

    // Pick the count by op
    // Data stays zero except under normalize
    // Spare code falls through as clz
    // A shift by the full width clears a zero operand
    always_comb begin
        sel_count = lead_count;
        sel_data  = '0;
        case (lane_op)
            OP_CTZ:  sel_count = trail_count;
            OP_NORM: sel_data  = lane_data << lead_count;
            default: sel_count = lead_count;
        endcase
    end

    // Result strobe trails the lane strobe by one cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= lane_valid;
        end
    end

    // Result payload held until the next strobe
    always_ff @(posedge clk) begin
        if (lane_valid) begin
            res_count <= sel_count;
            res_data  <= sel_data;
            res_zero  <= (lane_data == '0);
            res_norm  <= (lane_op == OP_NORM);
        end
    end

    // Count saturates at the full width
    a_count_range : assert property (@(posedge clk) disable iff (!rst_n)
        res_valid |-> (res_count <= scan_count_t'(COUNT_MAX)));

    // Normalized data of a nonzero operand has its top bit set
    a_norm_top_bit : assert property (@(posedge clk) disable iff (!rst_n)
        res_valid && res_norm && !res_zero |-> res_data[`NX_DATA_WIDTH-1]);

endmodule : nx_scan_lane

/* design/nx_scan_op_pkg.sv */
// Operation encoding for bit-scan requests
package nx_scan_op_pkg;

    // Operation codes carried with each request
    // Code 2'd3 is unused, lanes treat it as a leading-zero count
    typedef enum logic [1:0] {
        // Zeros above the highest set bit
        OP_CLZ  = 2'd0,
        // Zeros below the lowest set bit
        OP_CTZ  = 2'd1,
        // Operand shifted up until bit 31 is set, plus the shift
        OP_NORM = 2'd2
    } scan_op_t;

endpackage : nx_scan_op_pkg

/* design/nx_scan_result_pkg.sv */
// Result formats of the bit-scan unit: count width, count type and full-scale count
`include "nx_bitscan_config.svh"

package nx_scan_result_pkg;

    // Needs one bit more than log2 of the width
    // An all-zero operand counts the full width
    localparam int COUNT_WIDTH = $clog2(`NX_DATA_WIDTH) + 1;

    // Count of an all-zero operand
    // Also the start value of the minimum search
    localparam int COUNT_MAX = `NX_DATA_WIDTH;

    // Count of zeros scanned before the first one, 0 to COUNT_MAX
    typedef logic [COUNT_WIDTH-1:0] scan_count_t;

endpackage : nx_scan_result_pkg

/* dv/nx_bitscan_tb.sv */
// Bit-scan unit testbench: LFSR operands checked against a bit-scan model and a result queue
`timescale 1ns/100ps
`include "nx_bitscan_config.svh"

module nx_bitscan_tb;

    import nx_scan_op_pkg::*;
    import nx_scan_result_pkg::*;

    typedef logic [`NX_LANES-1:0][`NX_DATA_WIDTH-1:0] lane_data_t;
    typedef scan_count_t [`NX_LANES-1:0]              lane_count_t;

    localparam int LATENCY     = 3;
    localparam int DRAIN_LIMIT = 50;

    logic                 clk;
    logic                 rst_n;
    logic                 in_valid;
    scan_op_t             in_op;
    logic [`NX_LANES-1:0] in_mask;
    lane_data_t           in_data;
    logic                 out_valid;
    logic [`NX_LANES-1:0] out_mask;
    lane_count_t          out_count;
    lane_data_t           out_data;
    logic [`NX_LANES-1:0] out_zero;
    scan_count_t          out_min_count;

    // Expected results in issue order, one entry per request
    logic [`NX_LANES-1:0] exp_mask_q[$];
    lane_count_t          exp_count_q[$];
    lane_data_t           exp_data_q[$];
    logic [`NX_LANES-1:0] exp_zero_q[$];
    scan_count_t          exp_min_q[$];
    int                   exp_cycle_q[$];

    int          errors;
    int          checks;
    int          tests_run;
    int          tests_failed;
    int          cycle_count;
    bit          aborted;
    logic [31:0] lfsr;

    nx_bitscan_top nx_bitscan_top_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_op         (in_op),
        .in_mask       (in_mask),
        .in_data       (in_data),
        .out_valid     (out_valid),
        .out_mask      (out_mask),
        .out_count     (out_count),
        .out_data      (out_data),
        .out_zero      (out_zero),
        .out_min_count (out_min_count)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Cycle stamp for the latency check
    always @(posedge clk) cycle_count <= cycle_count + 1;

    // One Galois step, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return r;
    endfunction

    // Random word shifted by 0 to 32, so every count shows up
    function automatic logic [`NX_DATA_WIDTH-1:0] make_operand(input bit to_left);
        logic [31:0] w;
        logic [31:0] amt;
        w   = rand_bits(32);
        amt = rand_bits(5);
        amt = amt + rand_bits(1);
        return to_left ? (w << amt) : (w >> amt);
    endfunction

    function automatic lane_data_t random_operands(input bit to_left);
        lane_data_t d;
        for (int i = 0; i < `NX_LANES; i++) d[i] = make_operand(to_left);
        return d;
    endfunction

    // Zeros above the highest one, full width when empty
    function automatic scan_count_t model_lead(input logic [`NX_DATA_WIDTH-1:0] v);
        scan_count_t n;
        bit          found;
        n     = '0;
        found = 1'b0;
        for (int b = `NX_DATA_WIDTH - 1; b >= 0; b--) begin
            if (v[b]) found = 1'b1;
            else if (!found) n = n + 1'b1;
        end
        return n;
    endfunction

    // Zeros below the lowest one
    function automatic scan_count_t model_trail(input logic [`NX_DATA_WIDTH-1:0] v);
        scan_count_t n;
        bit          found;
        n     = '0;
        found = 1'b0;
        for (int b = 0; b < `NX_DATA_WIDTH; b++) begin
            if (v[b]) found = 1'b1;
            else if (!found) n = n + 1'b1;
        end
        return n;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error: %s = 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    // Model the request, then drive it 2 ns after the edge
    task automatic drive_request(input scan_op_t op, input logic [`NX_LANES-1:0] mask,
                                 input lane_data_t data);
        lane_count_t          cnt;
        lane_data_t           dat;
        logic [`NX_LANES-1:0] zro;
        scan_count_t          lead;
        scan_count_t          mn;
        mn = scan_count_t'(COUNT_MAX);
        for (int i = 0; i < `NX_LANES; i++) begin
            lead   = model_lead(data[i]);
            // Spare op code counts like clz
            cnt[i] = (op == OP_CTZ) ? model_trail(data[i]) : lead;
            dat[i] = (op == OP_NORM) ? (data[i] << lead) : '0;
            zro[i] = (data[i] == '0);
            if (mask[i] && (cnt[i] < mn)) mn = cnt[i];
        end
        @(posedge clk);
        #2;
        in_valid = 1'b1;
        in_op    = op;
        in_mask  = mask;
        in_data  = data;
        exp_mask_q.push_back(mask);
        exp_count_q.push_back(cnt);
        exp_data_q.push_back(dat);
        exp_zero_q.push_back(zro);
        exp_min_q.push_back(mn);
        exp_cycle_q.push_back(cycle_count);
    endtask

    // Junk on an idle bus must not reach any lane
    task automatic drive_idle();
        @(posedge clk);
        #2;
        in_valid = 1'b0;
        in_mask  = `NX_LANES'(rand_bits(`NX_LANES));
        for (int i = 0; i < `NX_LANES; i++) in_data[i] = rand_bits(32);
    endtask

    task automatic check_result();
        logic [`NX_LANES-1:0] mask;
        lane_count_t          cnt;
        lane_data_t           dat;
        logic [`NX_LANES-1:0] zro;
        scan_count_t          mn;
        int                   issued;
        mask   = exp_mask_q.pop_front();
        cnt    = exp_count_q.pop_front();
        dat    = exp_data_q.pop_front();
        zro    = exp_zero_q.pop_front();
        mn     = exp_min_q.pop_front();
        issued = exp_cycle_q.pop_front();
        check_value("latency", 64'(cycle_count - issued), 64'(LATENCY));
        check_value("out_mask", 64'(out_mask), 64'(mask));
        check_value("out_min_count", 64'(out_min_count), 64'(mn));
        // Unmasked lanes hold an older result
        for (int i = 0; i < `NX_LANES; i++) begin
            if (mask[i]) begin
                check_value($sformatf("out_count[%0d]", i), 64'(out_count[i]), 64'(cnt[i]));
                check_value($sformatf("out_data[%0d]", i), 64'(out_data[i]), 64'(dat[i]));
                check_value($sformatf("out_zero[%0d]", i), 64'(out_zero[i]), 64'(zro[i]));
            end
        end
    endtask

    // Outputs are sampled mid-cycle, away from both edges
    always @(negedge clk) begin
        if (rst_n && (out_valid === 1'b1)) begin
            if (exp_mask_q.size() == 0) begin
                errors++;
                $display("out_valid rose with no request pending at %0t", $time);
            end else begin
                check_result();
            end
        end
    end

    task automatic wait_drain();
        int n;
        n = 0;
        while ((exp_mask_q.size() != 0) && (n < DRAIN_LIMIT)) begin
            @(negedge clk);
            n++;
        end
        if (exp_mask_q.size() != 0) begin
            $display("timeout: %0d results still missing after %0d cycles",
                     exp_mask_q.size(), n);
            aborted = 1'b1;
        end
    endtask

    task automatic end_test(input int num, input string name, input int err_before);
        tests_run++;
        if ((errors != err_before) || aborted) begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", num, name, errors - err_before);
        end else begin
            $display("test %0d %s: passed", num, name);
        end
    endtask

    task automatic test_reset();
        int err_before;
        err_before = errors;
        repeat (8) begin
            @(posedge clk);
            #2;
            check_value("out_valid", 64'(out_valid), 64'(0));
        end
        rst_n = 1'b1;
        repeat (4) begin
            @(negedge clk);
            check_value("out_valid", 64'(out_valid), 64'(0));
        end
        end_test(1, "reset state", err_before);
    endtask

    // One op on all lanes, zero operands first, random idle gaps
    task automatic test_scan(input int num, input string name, input scan_op_t op,
                             input bit to_left);
        int          err_before;
        logic [31:0] gap;
        err_before = errors;
        drive_request(op, '1, '0);
        for (int n = 0; n < 32; n++) begin
            drive_request(op, '1, random_operands(to_left));
            gap = rand_bits(1);
            if (gap[0]) drive_idle();
        end
        drive_idle();
        wait_drain();
        end_test(num, name, err_before);
    endtask

    // Random ops and masks, starting with an empty mask
    task automatic test_mixed(input int num, input string name, input bit with_gaps);
        int          err_before;
        logic [31:0] op_code;
        logic [31:0] dir;
        logic [31:0] gap;
        err_before = errors;
        drive_request(OP_CLZ, '0, random_operands(1'b0));
        for (int n = 0; n < 40; n++) begin
            op_code = rand_bits(2);
            dir     = rand_bits(1);
            drive_request(scan_op_t'(op_code[1:0]), `NX_LANES'(rand_bits(`NX_LANES)),
                          random_operands(dir[0]));
            gap = rand_bits(1);
            if (with_gaps && gap[0]) drive_idle();
        end
        drive_idle();
        wait_drain();
        end_test(num, name, err_before);
    endtask

    initial begin
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        in_op        = OP_CLZ;
        in_mask      = '0;
        in_data      = '0;
        lfsr         = 32'h8cfe3545;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        cycle_count  = 0;
        aborted      = 1'b0;
        test_reset();
        if (!aborted) test_scan(2, "leading-zero count", OP_CLZ, 1'b0);
        if (!aborted) test_scan(3, "trailing-zero count", OP_CTZ, 1'b1);
        if (!aborted) test_scan(4, "normalize", OP_NORM, 1'b0);
        if (!aborted) test_mixed(5, "masking and minimum", 1'b1);
        if (!aborted) test_mixed(6, "back-to-back flow", 1'b0);
        $display("tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if ((errors == 0) && !aborted) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule : nx_bitscan_tb

/* src.f */
+incdir+design
design/nx_scan_op_pkg.sv
design/nx_scan_result_pkg.sv
design/nx_clz.sv
design/nx_scan_dispatch.sv
design/nx_scan_lane.sv
design/nx_scan_collect.sv
design/nx_bitscan_top.sv
dv/nx_bitscan_tb.sv
